/* verification/host_testdata.txt */
# op reg bytesel data expected, all hex; op W write, R read, G one-cycle select glitch
# expected is checked for R only, data is driven for W and G
R 0 0 00 00
R 0 1 00 00
R 3 0 00 00
R 3 1 00 00
W 3 0 12 00
W 3 1 34 00
R 3 0 00 12
R 3 1 00 34
G 3 1 ff 00
R 3 0 00 12
R 3 1 00 34
W c 0 55 00
W c 1 66 00
R c 0 00 00
R c 1 00 00
R 4 1 00 00
R f 0 00 00
R 3 1 00 34
W 0 0 00 00
W 0 1 10 00
W 3 0 ab 00
W 2 1 01 00
R 2 0 00 00
R 2 1 00 01
W 1 0 a1 00
W 1 1 b2 00
W 1 0 c3 00
W 1 1 d4 00
W 1 0 e5 00
W 1 1 f6 00
R 0 1 00 13
W 0 0 00 00
W 0 1 10 00
R 1 0 00 a1
R 1 1 00 b2
R 1 0 00 c3
R 1 1 00 d4
R 1 0 00 e5
R 1 1 00 f6
R 0 1 00 13

/* flist.f */
hw/xosera_pkg.sv
hw/bus_interface.sv
hw/reg_block.sv
hw/vram.sv
hw/xosera_host_top.sv
verification/xosera_host_checker.sv
verification/xosera_host_tb.sv

/* Makefile */
SIM   := verilator
FLAGS := --binary --timing --assert
TOP   := xosera_host_tb
FLIST := flist.f
PASS  := Finished with no errors

.PHONY: help test clean

help:
	@echo "test   build with $(SIM) and run the simulation"
	@echo "clean  remove build output"

test:
	$(SIM) $(FLAGS) --top-module $(TOP) -f $(FLIST)
	@out="$$(./obj_dir/V$(TOP))"; echo "$$out"; echo "$$out" | grep -q "$(PASS)"

clean:
	rm -rf obj_dir

/* verification/xosera_host_tb.sv */
`timescale 1ns/1ps

module xosera_host_tb import xosera_pkg::*;;

    localparam int    CLK_PERIOD   = 20;           // ns
    localparam int    RESET_CYCLES = 10;
    localparam int    HOLD_CYCLES  = 8;            // bus inputs held per access
    localparam int    STB_TIMEOUT  = 6;            // cycles allowed for a strobe to show
    localparam string DATA_FILE    = "verification/host_testdata.txt";

    logic       clk;
    logic       reset_i;
    logic       bus_cs_n;
    logic       bus_rd_nwr;
    logic [3:0] bus_reg_num;
    logic       bus_bytesel;
    logic [7:0] bus_data;
    logic [7:0] bus_data_o;

    xosera_host_top #(
        .VRAM_AW (8)
    ) DUT (
        .clk           (clk),
        .reset_i       (reset_i),
        .bus_cs_n_i    (bus_cs_n),
        .bus_rd_nwr_i  (bus_rd_nwr),
        .bus_reg_num_i (bus_reg_num),
        .bus_bytesel_i (bus_bytesel),
        .bus_data_i    (bus_data),
        .bus_data_o    (bus_data_o)
    );

    initial begin
        clk = 1'b0;
        forever #(CLK_PERIOD / 2) clk = ~clk;
    end

    task automatic abort_run(input string why);
        $display("%s", why);
        $display("Finished with errors");
        $fatal(1, "simulation stopped");
    endtask

    task automatic check_byte(input string name, input logic [7:0] exp, input logic [7:0] act);
        if (act !== exp) begin
            abort_run($sformatf("** Error: %s expected %h actual %h", name, exp, act));
        end
    endtask

    task automatic check_reg(input string name, input xr_reg_e exp, input xr_reg_e act);
        if (act !== exp) begin
            abort_run($sformatf("** Error: %s register expected %h actual %h", name, exp, act));
        end
    endtask

    // waits for the write or read strobe at the register block input
    task automatic wait_strobe(input string name, input bit want_wr, inout int edges);
        int   cycles;
        logic stb;
        cycles = 0;
        stb    = 1'b0;
        while (!stb) begin
            @(posedge clk);
            #1;                                    // look after the edge has settled
            edges++;
            cycles++;
            stb = want_wr ? DUT.u_reg_block.req_i.wr_stb : DUT.u_reg_block.req_i.rd_stb;
            if (!stb && cycles >= STB_TIMEOUT) begin
                abort_run($sformatf("%s: DUT did not respond with a strobe", name));
            end
        end
    endtask

    // one full host access where edge 0 is the edge before the inputs change
    task automatic bus_access(input string name, input logic [7:0] op,
                              input logic [3:0] reg_num, input logic bsel,
                              input logic [7:0] data, input logic [7:0] exp);
        int edges;
        @(posedge clk);
        #2;
        bus_cs_n    = 1'b0;
        bus_rd_nwr  = (op == "R");
        bus_reg_num = reg_num;
        bus_bytesel = bsel;
        bus_data    = data;
        repeat (3) @(posedge clk);
        #(CLK_PERIOD - 2);                         // just before edge 4 while the byte is stable
        check_reg(name, xr_reg_e'(reg_num), DUT.u_reg_block.req_i.reg_num);
        if (op == "R") begin
            check_byte(name, exp, bus_data_o);
        end
        edges = 3;
        if (op == "R" || bsel) begin
            wait_strobe(name, op != "R", edges);   // even writes give no strobe
        end
        while (edges < HOLD_CYCLES) begin
            @(posedge clk);
            edges++;
        end
        #2;
        bus_cs_n = 1'b1;
    endtask

    // select low for a single cycle that the filter has to reject
    task automatic glitch_pulse(input string name, input logic [3:0] reg_num,
                                input logic bsel, input logic [7:0] data);
        int cycles;
        @(posedge clk);
        #2;
        bus_cs_n    = 1'b0;
        bus_rd_nwr  = 1'b0;                        // posed as a write
        bus_reg_num = reg_num;
        bus_bytesel = bsel;
        bus_data    = data;
        @(posedge clk);
        #2;
        bus_cs_n = 1'b1;
        for (cycles = 0; cycles < HOLD_CYCLES; cycles++) begin
            @(posedge clk);
            #1;
            if (DUT.u_reg_block.req_i.wr_stb || DUT.u_reg_block.req_i.rd_stb) begin
                abort_run($sformatf("%s: one-cycle select pulse produced a strobe", name));
            end
        end
    endtask

    initial begin
        int         fd;
        int         code;
        int         line_no;
        int         ops;
        int         gap;
        string      line;
        string      name;
        logic [7:0] op;
        logic [3:0] reg_num;
        logic       bsel;
        logic [7:0] data;
        logic [7:0] exp;

        void'($urandom(70));                       // seeds the idle gap generator
        bus_cs_n    = 1'b1;                        // bus idle
        bus_rd_nwr  = 1'b1;
        bus_reg_num = 4'h0;
        bus_bytesel = 1'b0;
        bus_data    = 8'h00;
        reset_i     = 1'b1;
        repeat (RESET_CYCLES) @(posedge clk);
        #2;
        reset_i = 1'b0;

        fd = $fopen(DATA_FILE, "r");
        if (fd == 0) begin
            abort_run("could not open the test data file");
        end
        line_no = 0;
        ops     = 0;
        while (!$feof(fd)) begin
            code = $fgets(line, fd);
            line_no++;
            if (code == 0 || line.len() < 2 || line.getc(0) == "#") begin
                continue;                          // blank or comment line
            end
            code = $sscanf(line, "%c %h %h %h %h", op, reg_num, bsel, data, exp);
            if (code != 5) begin
                abort_run($sformatf("test data line %0d could not be parsed", line_no));
            end
            name = $sformatf("line %0d %c reg %0h byte %0h", line_no, op, reg_num, bsel);
            if (op == "G") begin
                glitch_pulse(name, reg_num, bsel, data);
            end else begin
                bus_access(name, op, reg_num, bsel, data, exp);
            end
            ops++;
            gap = 1 + int'($urandom % 4);          // select idle between accesses
            repeat (gap) @(posedge clk);
        end
        $fclose(fd);
        if (ops == 0) begin
            abort_run("the test data file held no bus operations");
        end else begin
            $display("Finished with no errors");
        end
        $finish;
    end

endmodule

/* verification/xosera_host_checker.sv */
`timescale 1ns/1ps

module xosera_host_checker import xosera_pkg::*; (
    input logic      clk,
    input logic      reset_i,
    input bus_req_t  req_i,                        // strobes into reg_block
    input vram_req_t vram_i                        // memory request out of reg_block
);

    // read and write strobes are exclusive
    assert property (@(posedge clk) disable iff (reset_i) !(req_i.wr_stb && req_i.rd_stb))
        else $error("write and read strobe high together");

    // strobes are single-cycle pulses
    assert property (@(posedge clk) disable iff (reset_i) req_i.wr_stb |=> !req_i.wr_stb)
        else $error("write strobe longer than one cycle");
    assert property (@(posedge clk) disable iff (reset_i) req_i.rd_stb |=> !req_i.rd_stb)
        else $error("read strobe longer than one cycle");

    // single port memory, one operation per cycle
    assert property (@(posedge clk) disable iff (reset_i) !(vram_i.wr_en && vram_i.rd_en))
        else $error("memory write and read requested together");

    // quiet once reset has been seen on a prior edge
    assert property (@(posedge clk) (reset_i && $past(reset_i)) |->
                     !(req_i.wr_stb || req_i.rd_stb || vram_i.wr_en || vram_i.rd_en))
        else $error("strobe or memory request active during reset");

endmodule

bind reg_block xosera_host_checker u_checker (
    .clk     (clk),
    .reset_i (reset_i),
    .req_i   (req_i),
    .vram_i  (vram_o)
);

/* hw/xosera_host_top.sv */
`timescale 1ns/1ps

module xosera_host_top import xosera_pkg::*; #(
    parameter int VRAM_AW = 8                      // memory is 2**VRAM_AW words
) (
    input  logic       clk,
    input  logic       reset_i,                    // synchronous reset
    input  logic       bus_cs_n_i,                 // asynchronous host bus
    input  logic       bus_rd_nwr_i,
    input  logic [3:0] bus_reg_num_i,
    input  logic       bus_bytesel_i,
    input  logic [7:0] bus_data_i,
    output logic [7:0] bus_data_o
);

    bus_req_t    bus_req;                          // register request
    logic [15:0] rd_word;                          // register read word
    vram_req_t   vram_req;                         // memory request
    logic [15:0] vram_rd_data;                     // memory read data

    bus_interface u_bus_interface (
        .clk           (clk),
        .reset_i       (reset_i),
        .bus_cs_n_i    (bus_cs_n_i),
        .bus_rd_nwr_i  (bus_rd_nwr_i),
        .bus_reg_num_i (bus_reg_num_i),
        .bus_bytesel_i (bus_bytesel_i),
        .bus_data_i    (bus_data_i),
        .bus_data_o    (bus_data_o),
        .req_o         (bus_req),
        .rd_word_i     (rd_word)
    );

    reg_block #(
        .VRAM_AW (VRAM_AW)
    ) u_reg_block (
        .clk         (clk),
        .reset_i     (reset_i),
        .req_i       (bus_req),
        .rd_word_o   (rd_word),
        .vram_o      (vram_req),
        .vram_data_i (vram_rd_data)
    );

    vram #(
        .VRAM_AW (VRAM_AW)
    ) u_vram (
        .clk       (clk),
        .req_i     (vram_req),
        .rd_data_o (vram_rd_data)
    );

endmodule

/* hw/vram.sv */
`timescale 1ns/1ps

module vram import xosera_pkg::*; #(
    parameter int VRAM_AW = 8                      // word address width
) (
    input  logic        clk,
    input  vram_req_t   req_i,                     // request from reg_block
    output logic [15:0] rd_data_o                  // registered read data
);

    localparam int DEPTH = 2 ** VRAM_AW;           // words in the array

    logic [15:0]        mem [DEPTH];               // word storage
    logic [VRAM_AW-1:0] word_addr;                 // in-range part of the address

    assign word_addr = req_i.addr[VRAM_AW-1:0];

    // single port
    // a write and a read in the same cycle would return the old word
    always_ff @(posedge clk) begin
        if (req_i.wr_en) begin
            mem[word_addr] <= req_i.wr_data;
        end
        if (req_i.rd_en) begin
            rd_data_o <= mem[word_addr];           // valid the cycle after rd_en
        end
    end

endmodule

/* hw/reg_block.sv */
`timescale 1ns/1ps

module reg_block import xosera_pkg::*; #(
    parameter int VRAM_AW = 8                      // memory word address width
) (
    input  logic        clk,
    input  logic        reset_i,                   // synchronous reset
    input  bus_req_t    req_i,                     // request from bus_interface
    output logic [15:0] rd_word_o,                 // word of the selected register
    output vram_req_t   vram_o,                    // memory request
    input  logic [15:0] vram_data_i                // memory read data, one cycle after rd_en
);

    // prefetch sequence after ADDR writes and DATA accesses
    typedef enum logic [1:0] {
        IDLE,                                      // buffer valid, nothing pending
        FETCH,                                     // rd_en at the new address
        LOAD                                       // memory data lands in the buffer
    } fetch_state_e;

    fetch_state_e state_r;

    logic [15:0] addr_r;                           // ADDR
    logic [15:0] inc_r;                            // INC, signed step
    logic [15:0] scratch_r;                        // SCRATCH
    logic [15:0] rd_buf_r;                         // prefetched word seen through DATA

    logic        data_wr;                          // DATA write this cycle
    logic        data_rd;                          // odd-byte DATA read this cycle

    assign data_wr = req_i.wr_stb && (req_i.reg_num == XR_DATA);
    assign data_rd = req_i.rd_stb && req_i.odd_byte && (req_i.reg_num == XR_DATA);

    always_ff @(posedge clk) begin
        if (reset_i) begin
            state_r   <= IDLE;
            addr_r    <= 16'h0000;
            inc_r     <= 16'h0000;
            scratch_r <= 16'h0000;
            rd_buf_r  <= 16'h0000;
        end else begin
            case (state_r)
                FETCH: state_r <= LOAD;
                LOAD: begin
                    rd_buf_r <= vram_data_i;       // prefetch complete
                    state_r  <= IDLE;
                end
                default: ;
            endcase

            // strobes are taken in any state, bus spacing keeps them apart
            if (req_i.wr_stb) begin
                case (req_i.reg_num)
                    XR_ADDR: begin
                        addr_r  <= req_i.wr_data;  // new address, then prefetch it
                        state_r <= FETCH;
                    end
                    XR_DATA: begin
                        addr_r  <= addr_r + inc_r; // memory written at old addr this cycle
                        state_r <= FETCH;
                    end
                    XR_INC:     inc_r     <= req_i.wr_data;
                    XR_SCRATCH: scratch_r <= req_i.wr_data;
                    default: ;                     // unused numbers drop writes
                endcase
            end

            if (data_rd) begin
                addr_r  <= addr_r + inc_r;         // host just took the old buffer
                state_r <= FETCH;
            end
        end
    end

    // read word for the register now on the bus
    always_comb begin
        case (req_i.reg_num)
            XR_ADDR:    rd_word_o = addr_r;
            XR_DATA:    rd_word_o = rd_buf_r;
            XR_INC:     rd_word_o = inc_r;
            XR_SCRATCH: rd_word_o = scratch_r;
            default:    rd_word_o = 16'h0000;      // 4 to 15 read as zero
        endcase
    end

    // memory request, address trimmed to the memory size
    always_comb begin
        vram_o.addr    = 16'(addr_r[VRAM_AW-1:0]);
        vram_o.wr_data = req_i.wr_data;
        vram_o.wr_en   = data_wr;
        vram_o.rd_en   = (state_r == FETCH);
    end

endmodule

/* hw/bus_interface.sv */
`timescale 1ns/1ps

module bus_interface import xosera_pkg::*; (
    input  logic        clk,                       // fast clock, well above bus rate
    input  logic        reset_i,                   // synchronous reset
    input  logic        bus_cs_n_i,                // register select, active low
    input  logic        bus_rd_nwr_i,              // 1 = read, 0 = write
    input  logic [3:0]  bus_reg_num_i,             // register number
    input  logic        bus_bytesel_i,             // 0 = even byte, 1 = odd byte
    input  logic [7:0]  bus_data_i,                // host write data
    output logic [7:0]  bus_data_o,                // host read data
    output bus_req_t    req_o,                     // request to reg_block
    input  logic [15:0] rd_word_i                  // word of the synchronized register
);

    // one synchronizer stage of the bus lines other than select
    typedef struct packed {
        logic       read;                          // active-high read
        logic       bytesel;                       // odd byte flag
        logic [3:0] reg_num;                       // register number
        logic [7:0] data;                          // data byte
    } bus_sample_t;

    bus_sample_t sync1_r;                          // first stage, may be metastable
    bus_sample_t sync2_r;                          // settled copy, the one acted on

    // select history, shifted right
    // bit 3 is the first stage, bit 2 the settled sample, bits 1:0 older samples
    logic [3:0]  sel_r;
    logic        sel_rise;                         // filtered rising edge of select
    logic        write;                            // settled access is a write

    logic        wr_stb_r;                         // write strobe
    logic        rd_stb_r;                         // read strobe

    logic [3:0]  even_reg_r;                       // register of the buffered even byte
    logic [7:0]  even_data_r;                      // buffered even byte

    // select must be seen on two samples in a row after a low sample,
    // so a single-cycle pulse never matches
    assign sel_rise = (sel_r[2:0] == 3'b110);
    assign write    = ~sync2_r.read;

    // read byte follows the settled bytesel continuously
    assign bus_data_o = sync2_r.bytesel ? rd_word_i[7:0] : rd_word_i[15:8];

    // synchronizers, payload only
    always_ff @(posedge clk) begin
        sync1_r.read    <= (bus_rd_nwr_i == RNW_READ);
        sync1_r.bytesel <= bus_bytesel_i;
        sync1_r.reg_num <= bus_reg_num_i;
        sync1_r.data    <= bus_data_i;
        sync2_r         <= sync1_r;
    end

    // select edge detect, strobes and even byte buffer
    always_ff @(posedge clk) begin
        if (reset_i) begin
            sel_r       <= 4'b0000;
            wr_stb_r    <= 1'b0;
            rd_stb_r    <= 1'b0;
            even_reg_r  <= 4'h0;
            even_data_r <= 8'h00;
        end else begin
            sel_r    <= {(bus_cs_n_i == CS_ENABLED), sel_r[3:1]};  // select made active high
            wr_stb_r <= 1'b0;                      // strobes default low
            rd_stb_r <= 1'b0;

            if (sel_rise) begin
                if (!write) begin
                    rd_stb_r <= 1'b1;              // every read gets a strobe
                end else if (sync2_r.bytesel) begin
                    wr_stb_r <= 1'b1;              // odd byte completes the word
                end else begin
                    even_reg_r  <= sync2_r.reg_num;  // hold even byte until odd arrives
                    even_data_r <= sync2_r.data;
                end
            end
        end
    end

    // request toward reg_block
    always_comb begin
        req_o.reg_num  = xr_reg_e'(sync2_r.reg_num);
        req_o.odd_byte = sync2_r.bytesel;
        req_o.wr_stb   = wr_stb_r;
        req_o.rd_stb   = rd_stb_r;
        if (sync2_r.reg_num == even_reg_r) begin
            req_o.wr_data = {even_data_r, sync2_r.data};  // matched pair, full word
        end else begin
            req_o.wr_data = {8'h00, sync2_r.data};        // lone odd byte, upper zero
        end
    end

endmodule

/* hw/xosera_pkg.sv */
package xosera_pkg;

    // host bus polarity
    localparam logic CS_ENABLED = 1'b0;            // bus_cs_n_i is active low
    localparam logic RNW_READ   = 1'b1;            // bus_rd_nwr_i high means read

    // host register numbers, 4 bits on the bus
    typedef enum logic [3:0] {
        XR_ADDR    = 4'h0,                         // memory address for DATA accesses
        XR_DATA    = 4'h1,                         // memory data window
        XR_INC     = 4'h2,                         // signed step added to ADDR after DATA
        XR_SCRATCH = 4'h3                          // plain storage
    } xr_reg_e;                                    // numbers 4 to 15 are unused

    // register request from bus_interface to reg_block
    // reg_num, wr_data and odd_byte follow the synchronized bus while select is held,
    // the strobes are single-cycle pulses
    typedef struct packed {
        xr_reg_e     reg_num;                      // synchronized register number
        logic [15:0] wr_data;                      // paired word for a write
        logic        odd_byte;                     // bytesel of the access, 1 for odd
        logic        wr_stb;                       // odd-byte write, one cycle
        logic        rd_stb;                       // any read access, one cycle
    } bus_req_t;                                   // 23 bits

    // memory request from reg_block to vram
    typedef struct packed {
        logic [15:0] addr;                         // word address, low VRAM_AW bits used
        logic [15:0] wr_data;                      // word to write
        logic        wr_en;                        // write at addr this cycle
        logic        rd_en;                        // read at addr, data next cycle
    } vram_req_t;                                  // 34 bits

endpackage
